// File: issue_queue_top.f
+incdir+rtl
+incdir+tests
rtl/issue_pkg.sv
rtl/issue_ctrl_fsm.sv
rtl/issue_latency_timer.sv
rtl/issue_entry_array.sv
rtl/issue_age_tracker.sv
rtl/issue_queue_top.sv
tests/issue_queue_tb.sv

// File: Bender.yml
package:
  name: issue_queue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/issue_pkg.sv
      - rtl/issue_ctrl_fsm.sv
      - rtl/issue_latency_timer.sv
      - rtl/issue_entry_array.sv
      - rtl/issue_age_tracker.sv
      - rtl/issue_queue_top.sv
  - target: test
    include_dirs:
      - rtl
      - tests
    files:
      - tests/issue_queue_tb.sv

// File: tests/issue_queue_tb_table.svh
`ifndef ISSUE_QUEUE_TB_TABLE_SVH
`define ISSUE_QUEUE_TB_TABLE_SVH

// columns: dispatch, dest, src, src_ready, payload, ext wakeup, ext tag, stall, flush, hold
// strobes act in the first cycle of a row, stall is held for all hold cycles
localparam int NUM_STEPS = 22;

localparam step_t STEPS [NUM_STEPS] = '{
    '{1'b1, 6'd1,  6'd0,  1'b1, 16'hc001, 1'b0, 6'd0,  1'b1, 1'b0, 8'd1},  // fill under stall
    '{1'b1, 6'd2,  6'd0,  1'b1, 16'hc002, 1'b0, 6'd0,  1'b1, 1'b0, 8'd1},
    '{1'b1, 6'd3,  6'd0,  1'b1, 16'hc003, 1'b0, 6'd0,  1'b1, 1'b0, 8'd1},
    '{1'b1, 6'd4,  6'd0,  1'b1, 16'hc004, 1'b0, 6'd0,  1'b1, 1'b0, 8'd3},  // queue full
    '{1'b0, 6'd0,  6'd0,  1'b0, 16'h0000, 1'b0, 6'd0,  1'b0, 1'b0, 8'd8},  // drain in age order
    '{1'b1, 6'd10, 6'd0,  1'b1, 16'hc00a, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // producer
    '{1'b1, 6'd11, 6'd10, 1'b0, 16'hc00b, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // waits on tag 10
    '{1'b1, 6'd12, 6'd0,  1'b1, 16'hc00c, 1'b0, 6'd0,  1'b0, 1'b0, 8'd8},  // younger, goes first
    '{1'b1, 6'd22, 6'd41, 1'b0, 16'hc016, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},
    '{1'b1, 6'd20, 6'd40, 1'b0, 16'hc014, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // lands in slot 1
    '{1'b0, 6'd0,  6'd0,  1'b0, 16'h0000, 1'b1, 6'd41, 1'b0, 1'b0, 8'd3},  // frees slot 0
    '{1'b1, 6'd21, 6'd40, 1'b0, 16'hc015, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // younger, in slot 0
    '{1'b0, 6'd0,  6'd0,  1'b0, 16'h0000, 1'b1, 6'd40, 1'b0, 1'b0, 8'd6},  // wakes both
    '{1'b1, 6'd24, 6'd0,  1'b1, 16'hc018, 1'b0, 6'd0,  1'b1, 1'b0, 8'd1},
    '{1'b1, 6'd25, 6'd0,  1'b1, 16'hc019, 1'b0, 6'd0,  1'b1, 1'b0, 8'd4},
    '{1'b0, 6'd0,  6'd0,  1'b0, 16'h0000, 1'b0, 6'd0,  1'b0, 1'b0, 8'd5},  // stall released
    '{1'b1, 6'd30, 6'd0,  1'b1, 16'hc01e, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // in flight at flush
    '{1'b1, 6'd31, 6'd33, 1'b0, 16'hc01f, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // flushed, never issues
    '{1'b0, 6'd0,  6'd0,  1'b0, 16'h0000, 1'b0, 6'd0,  1'b0, 1'b1, 8'd2},
    '{1'b1, 6'd34, 6'd30, 1'b0, 16'hc022, 1'b0, 6'd0,  1'b0, 1'b0, 8'd1},  // stale tag 30 slot
    '{1'b1, 6'd35, 6'd0,  1'b1, 16'hc023, 1'b0, 6'd0,  1'b0, 1'b0, 8'd2},
    '{1'b0, 6'd0,  6'd0,  1'b0, 16'h0000, 1'b1, 6'd30, 1'b0, 1'b0, 8'd8}
};

// issue order of the rows above, dest tag then payload
localparam int EXP_N = 15;

localparam issue_t EXP_ORDER [EXP_N] = '{
    {6'd1,  16'hc001}, {6'd2,  16'hc002}, {6'd3,  16'hc003}, {6'd4,  16'hc004},
    {6'd10, 16'hc00a}, {6'd12, 16'hc00c}, {6'd11, 16'hc00b},
    {6'd22, 16'hc016}, {6'd20, 16'hc014}, {6'd21, 16'hc015},
    {6'd24, 16'hc018}, {6'd25, 16'hc019},
    {6'd30, 16'hc01e}, {6'd35, 16'hc023}, {6'd34, 16'hc022}
};

`endif

// File: tests/issue_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_queue_tb;
    import issue_pkg::*;

    typedef struct packed {
        logic        dispatch;
        tag_t        dest;
        tag_t        src;
        logic        src_ready;
        logic [15:0] payload;
        logic        ext;
        tag_t        ext_tag;
        logic        stall;
        logic        flush;
        logic [7:0]  hold;
    } step_t;

    `include "issue_queue_tb_table.svh"

    localparam int RAND_N = 4;  // random filler dispatches

    logic   clk_i;
    logic   reset_i;
    logic   dispatch_i;
    uop_t   dispatch_uop_i;
    logic   ext_wakeup_i;
    tag_t   ext_wakeup_tag_i;
    logic   stall_i;
    logic   flush_i;
    logic   issue_valid_o;
    issue_t issue_o;
    logic   full_o;
    logic   empty_o;

    // reference model state
    entry_mask_t          m_valid = '0;
    entry_mask_t          m_rdy = '0;
    tag_t                 m_dest [`ISSUE_DEPTH];
    tag_t                 m_src [`ISSUE_DEPTH];
    uop_payload_t         m_pay [`ISSUE_DEPTH];
    int                   m_seq [`ISSUE_DEPTH];  // dispatch order
    int                   seq_cnt = 0;
    ctrl_state_t          m_state = IDLE;
    logic [`EXEC_LAT-1:0] m_tmr_v = '0;
    tag_t                 m_tmr_t [`EXEC_LAT];
    logic                 exp_valid = 1'b0;
    issue_t               exp_issue;
    int                   issue_cnt = 0;
    int                   seed = 32'h2a1e;

    issue_queue_top UUT (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .dispatch_i       (dispatch_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .ext_wakeup_i     (ext_wakeup_i),
        .ext_wakeup_tag_i (ext_wakeup_tag_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .issue_valid_o    (issue_valid_o),
        .issue_o          (issue_o),
        .full_o           (full_o),
        .empty_o          (empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic tag_woken(tag_t t, logic tv, tag_t tt);
        return (tv && tt == t) || (ext_wakeup_i && ext_wakeup_tag_i == t);
    endfunction

    always @(posedge clk_i) begin : ref_model
        int   g;
        int   slot;
        logic en;
        logic clr;
        logic was_empty;
        logic wb_v;
        tag_t wb_t;
        en        = (m_state == RUN) && !stall_i && !flush_i;
        clr       = reset_i || (m_state == FLUSH);
        was_empty = (m_valid == '0);
        wb_v      = m_tmr_v[`EXEC_LAT-1];  // broadcast seen this cycle
        wb_t      = m_tmr_t[`EXEC_LAT-1];
        g         = -1;
        slot      = -1;
        for (int k = `ISSUE_DEPTH - 1; k >= 0; k--) begin
            if (!m_valid[k]) begin
                slot = k;  // lowest free slot
            end
            if (m_valid[k] && m_rdy[k] && (g < 0 || m_seq[k] < m_seq[g])) begin
                g = k;  // oldest ready
            end
        end
        for (int s = `EXEC_LAT - 1; s > 0; s--) begin
            m_tmr_v[s] = m_tmr_v[s-1];
            m_tmr_t[s] = m_tmr_t[s-1];
        end
        m_tmr_v[0] = exp_valid;  // the visible issue enters execution
        m_tmr_t[0] = exp_issue.dest_tag;
        exp_valid  = en && (g >= 0);
        if (exp_valid) begin
            exp_issue  = {m_dest[g], m_pay[g]};
            m_valid[g] = 1'b0;
        end
        for (int k = 0; k < `ISSUE_DEPTH; k++) begin
            if (m_valid[k] && tag_woken(m_src[k], wb_v, wb_t)) begin
                m_rdy[k] = 1'b1;
            end
        end
        if (dispatch_i && slot >= 0) begin
            m_valid[slot] = 1'b1;
            m_rdy[slot]   = dispatch_uop_i.src_ready ||
                            tag_woken(dispatch_uop_i.src_tag, wb_v, wb_t);
            m_dest[slot]  = dispatch_uop_i.dest_tag;
            m_src[slot]   = dispatch_uop_i.src_tag;
            m_pay[slot]   = dispatch_uop_i.payload;
            m_seq[slot]   = seq_cnt;
            seq_cnt++;
        end
        case (m_state)
            IDLE:    m_state = was_empty ? IDLE : (stall_i ? STALL : RUN);
            RUN:     m_state = stall_i ? STALL : RUN;
            STALL:   m_state = stall_i ? STALL : RUN;
            default: m_state = IDLE;
        endcase
        if (flush_i) begin
            m_state = FLUSH;
        end
        if (clr) begin
            m_valid   = '0;  // queue, timer and issue register emptied
            m_tmr_v   = '0;
            exp_valid = 1'b0;
        end
        if (reset_i) begin
            m_state = IDLE;
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_outputs();
        assert (issue_valid_o === exp_valid && (!exp_valid || issue_o === exp_issue))
            else abort_run($sformatf("error at %0t: issue %b/%h, expected %b/%h",
                                     $time, issue_valid_o, issue_o, exp_valid, exp_issue));
        assert (full_o === (&m_valid) && empty_o === (~|m_valid))
            else abort_run($sformatf("error at %0t: full/empty %b/%b, expected %b/%b",
                                     $time, full_o, empty_o, &m_valid, ~|m_valid));
        if (issue_valid_o) begin
            if (issue_cnt < EXP_N) begin
                assert (issue_o === EXP_ORDER[issue_cnt])
                    else abort_run($sformatf("error at %0t: issue %0d is %h, expected %h",
                                             $time, issue_cnt, issue_o, EXP_ORDER[issue_cnt]));
            end
            issue_cnt++;
        end
    endtask

    task automatic run_step(step_t st);
        for (int h = 0; h < int'(st.hold); h++) begin
            dispatch_i               = st.dispatch && (h == 0);  // strobes last one cycle
            dispatch_uop_i.dest_tag  = st.dest;
            dispatch_uop_i.src_tag   = st.src;
            dispatch_uop_i.src_ready = st.src_ready;
            dispatch_uop_i.payload   = st.payload;
            ext_wakeup_i             = st.ext && (h == 0);
            ext_wakeup_tag_i         = st.ext_tag;
            stall_i                  = st.stall;
            flush_i                  = st.flush && (h == 0);
            @(negedge clk_i);
            check_outputs();
        end
    endtask

    initial begin : stimulus
        step_t rnd;
        reset_i          = 1'b1;
        dispatch_i       = 1'b0;
        dispatch_uop_i   = '0;
        ext_wakeup_i     = 1'b0;
        ext_wakeup_tag_i = '0;
        stall_i          = 1'b0;
        flush_i          = 1'b0;
        repeat (5) @(negedge clk_i);
        reset_i = 1'b0;
        assert (empty_o && !full_o && !issue_valid_o)
            else abort_run($sformatf("error at %0t: wrong state after reset", $time));
        for (int r = 0; r < NUM_STEPS; r++) begin
            run_step(STEPS[r]);
        end
        for (int i = 0; i < RAND_N; i++) begin
            rnd           = '0;
            rnd.dispatch  = 1'b1;
            rnd.dest      = tag_t'(40 + i);
            rnd.src       = 6'h3f;  // only the wakeup below produces this tag
            rnd.src_ready = 1'($random(seed));
            rnd.payload   = 16'hd000 + 16'(i);
            rnd.hold      = 8'd1;
            run_step(rnd);
        end
        rnd         = '0;
        rnd.ext     = 1'b1;
        rnd.ext_tag = 6'h3f;
        rnd.hold    = 8'd10;
        run_step(rnd);
        assert (issue_cnt == EXP_N + RAND_N && empty_o) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run($sformatf("error at %0t: %0d ops issued, expected %0d",
                                $time, issue_cnt, EXP_N + RAND_N));
        end
    end

    initial begin : watchdog
        int max_hold;
        int limit;
        max_hold = 0;
        for (int r = 0; r < NUM_STEPS; r++) begin
            if (int'(STEPS[r].hold) > max_hold) begin
                max_hold = int'(STEPS[r].hold);
            end
        end
        limit = NUM_STEPS * max_hold + 200;
        repeat (limit) @(posedge clk_i);
        abort_run($sformatf("timeout: the test did not finish within %0d cycles", limit));
    end

endmodule

`default_nettype wire

// File: rtl/issue_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_top (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              dispatch_i,
    input  issue_pkg::uop_t   dispatch_uop_i,
    input  logic              ext_wakeup_i,
    input  issue_pkg::tag_t   ext_wakeup_tag_i,
    input  logic              stall_i,
    input  logic              flush_i,
    output logic              issue_valid_o,
    output issue_pkg::issue_t issue_o,
    output logic              full_o,
    output logic              empty_o
);
    import issue_pkg::*;

    logic        issue_en;
    logic        clear;
    entry_mask_t occupied;
    entry_mask_t ready;
    entry_mask_t alloc_mask;
    entry_mask_t grant;
    logic        wb_valid;  // timer wakeup
    tag_t        wb_tag;

    issue_ctrl_fsm u_ctrl (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .empty_i    (empty_o),
        .issue_en_o (issue_en),
        .clear_o    (clear),
        .state_o    ()
    );

    issue_latency_timer u_timer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .clear_i     (clear),
        .start_i     (issue_valid_o),
        .start_tag_i (issue_o.dest_tag),
        .wb_valid_o  (wb_valid),
        .wb_tag_o    (wb_tag)
    );

    issue_entry_array #(
        .payload_t (uop_payload_t)
    ) u_array (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .clear_i        (clear),
        .alloc_i        (dispatch_i),
        .alloc_uop_i    (dispatch_uop_i),
        .wake_a_valid_i (wb_valid),
        .wake_b_valid_i (ext_wakeup_i),
        .wake_a_tag_i   (wb_tag),
        .wake_b_tag_i   (ext_wakeup_tag_i),
        .grant_i        (grant),
        .occupied_o     (occupied),
        .ready_o        (ready),
        .alloc_mask_o   (alloc_mask),
        .issue_valid_o  (issue_valid_o),
        .issue_o        (issue_o),
        .full_o         (full_o),
        .empty_o        (empty_o)
    );

    issue_age_tracker u_age (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .clear_i      (clear),
        .issue_en_i   (issue_en),
        .occupied_i   (occupied),
        .ready_i      (ready),
        .alloc_mask_i (alloc_mask),
        .grant_o      (grant)
    );

endmodule

`default_nettype wire

// File: rtl/issue_age_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_age_tracker (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   clear_i,
    input  logic                   issue_en_i,
    input  issue_pkg::entry_mask_t occupied_i,
    input  issue_pkg::entry_mask_t ready_i,
    input  issue_pkg::entry_mask_t alloc_mask_i,
    output issue_pkg::entry_mask_t grant_o
);
    import issue_pkg::*;

    age_t        age_q [`ISSUE_DEPTH];  // 1 = youngest, 0 = empty
    age_t        best_age;
    entry_mask_t cand;
    entry_mask_t sel;
    logic        alloc_any;
    logic        grant_any;

    // oldest ready entry, strict compare keeps the lowest index on a tie
    always_comb begin
        cand     = ready_i & occupied_i;
        best_age = '0;
        sel      = '0;
        for (int k = 0; k < `ISSUE_DEPTH; k++) begin
            if (cand[k] && (age_q[k] > best_age)) begin
                best_age = age_q[k];
                sel      = '0;
                sel[k]   = 1'b1;
            end
        end
        grant_o = (issue_en_i && (best_age != '0)) ? sel : '0;
    end

    assign alloc_any = |alloc_mask_i;
    assign grant_any = |grant_o;

    // ages stay a dense 1..n over the occupied entries
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            for (int k = 0; k < `ISSUE_DEPTH; k++) begin
                age_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < `ISSUE_DEPTH; k++) begin
                if (alloc_mask_i[k]) begin
                    age_q[k] <= age_t'(1);  // newest op
                end else if (grant_o[k] || !occupied_i[k]) begin
                    age_q[k] <= '0;
                end else begin
                    // everyone ages on dispatch, older ones close the gap on issue
                    age_q[k] <= age_q[k] + age_t'(alloc_any)
                                - age_t'(grant_any && (age_q[k] > best_age));
                end
            end
        end
    end

    for (genvar i = 0; i < `ISSUE_DEPTH; i++) begin : g_age_chk
        for (genvar j = i + 1; j < `ISSUE_DEPTH; j++) begin : g_pair
            a_age_unique: assert property (@(posedge clk_i) disable iff (reset_i)
                (occupied_i[i] && occupied_i[j]) |-> (age_q[i] != age_q[j]))
                else $error("entries %0d and %0d share an age", i, j);
        end
    end

endmodule

`default_nettype wire

// File: rtl/issue_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_entry_array #(
    parameter type payload_t = issue_pkg::uop_payload_t
) (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   clear_i,
    input  logic                   alloc_i,
    input  issue_pkg::uop_t        alloc_uop_i,
    input  logic                   wake_a_valid_i,
    input  logic                   wake_b_valid_i,
    input  issue_pkg::tag_t        wake_a_tag_i,
    input  issue_pkg::tag_t        wake_b_tag_i,
    input  issue_pkg::entry_mask_t grant_i,
    output issue_pkg::entry_mask_t occupied_o,
    output issue_pkg::entry_mask_t ready_o,
    output issue_pkg::entry_mask_t alloc_mask_o,
    output logic                   issue_valid_o,
    output issue_pkg::issue_t      issue_o,
    output logic                   full_o,
    output logic                   empty_o
);
    import issue_pkg::*;

    entry_mask_t occupied_q;
    entry_mask_t src_rdy_q;
    tag_t        dest_tag_q [`ISSUE_DEPTH];
    tag_t        src_tag_q  [`ISSUE_DEPTH];
    payload_t    payload_q  [`ISSUE_DEPTH];

    entry_mask_t free_mask;   // lowest free slot, one-hot
    entry_mask_t wake_hit;
    logic        alloc_hit;   // incoming op woken in its dispatch cycle
    logic        issue_valid_q;
    issue_t      issue_d;
    issue_t      issue_q;

    // scan from the top so the lowest free index wins
    always_comb begin
        free_mask = '0;
        for (int k = `ISSUE_DEPTH - 1; k >= 0; k--) begin
            if (!occupied_q[k]) begin
                free_mask    = '0;
                free_mask[k] = 1'b1;
            end
        end
    end

    assign alloc_mask_o = (alloc_i && !full_o) ? free_mask : '0;  // drop under full

    // two independent match ports, timer and external producer
    always_comb begin
        for (int k = 0; k < `ISSUE_DEPTH; k++) begin
            wake_hit[k] = occupied_q[k] &&
                          ((wake_a_valid_i && (wake_a_tag_i == src_tag_q[k])) ||
                           (wake_b_valid_i && (wake_b_tag_i == src_tag_q[k])));
        end
        alloc_hit = (wake_a_valid_i && (wake_a_tag_i == alloc_uop_i.src_tag)) ||
                    (wake_b_valid_i && (wake_b_tag_i == alloc_uop_i.src_tag));
    end

    // grant is one-hot, so an OR over the slots is the read mux
    always_comb begin
        issue_d = '0;
        for (int k = 0; k < `ISSUE_DEPTH; k++) begin
            if (grant_i[k]) begin
                issue_d.dest_tag = dest_tag_q[k];
                issue_d.payload  = uop_payload_t'(payload_q[k]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            occupied_q    <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            occupied_q    <= (occupied_q & ~grant_i) | alloc_mask_o;  // free on issue
            issue_valid_q <= |grant_i;
        end
    end

    always_ff @(posedge clk_i) begin
        issue_q <= issue_d;
        for (int k = 0; k < `ISSUE_DEPTH; k++) begin
            if (alloc_mask_o[k]) begin
                dest_tag_q[k] <= alloc_uop_i.dest_tag;
                src_tag_q[k]  <= alloc_uop_i.src_tag;
                payload_q[k]  <= payload_t'(alloc_uop_i.payload);
                src_rdy_q[k]  <= alloc_uop_i.src_ready || alloc_hit;
            end else if (wake_hit[k]) begin
                src_rdy_q[k]  <= 1'b1;
            end
        end
    end

    assign occupied_o    = occupied_q;
    assign ready_o       = occupied_q & src_rdy_q;  // ready the cycle after write or wakeup
    assign issue_valid_o = issue_valid_q;
    assign issue_o       = issue_q;
    assign full_o        = &occupied_q;
    assign empty_o       = ~|occupied_q;

    a_no_alloc_full: assert property (@(posedge clk_i) disable iff (reset_i)
        alloc_i |-> !full_o)
        else $error("dispatch while queue full, op dropped");

    a_grant_legal: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(grant_i) && ((grant_i & ~ready_o) == '0))
        else $error("grant not one-hot or on a non-ready entry");

endmodule

`default_nettype wire

// File: rtl/issue_latency_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "issue_config.svh"

module issue_latency_timer (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            clear_i,
    input  logic            start_i,
    input  issue_pkg::tag_t start_tag_i,
    output logic            wb_valid_o,
    output issue_pkg::tag_t wb_tag_o
);
    import issue_pkg::*;

    // one stage per execution cycle, so EXEC_LAT ops can be in flight
    logic [`EXEC_LAT-1:0] valid_q;
    tag_t                 tag_q [`EXEC_LAT];

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            valid_q <= '0;  // flushed ops must never wake anything
        end else begin
            valid_q[0] <= start_i;
            for (int s = 1; s < `EXEC_LAT; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // tags just follow their valid bits
    always_ff @(posedge clk_i) begin
        tag_q[0] <= start_tag_i;
        for (int s = 1; s < `EXEC_LAT; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
    end

    assign wb_valid_o = valid_q[`EXEC_LAT-1];  // last stage broadcasts
    assign wb_tag_o   = tag_q[`EXEC_LAT-1];

endmodule

`default_nettype wire

// File: rtl/issue_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl_fsm (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   empty_i,
    output logic                   issue_en_o,
    output logic                   clear_o,
    output issue_pkg::ctrl_state_t state_o
);
    import issue_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!empty_i) begin
                    state_d = stall_i ? STALL : RUN;  // first op arrived
                end
            end
            RUN: begin
                if (stall_i) begin
                    state_d = STALL;
                end
            end
            STALL: begin
                if (!stall_i) begin
                    state_d = RUN;  // execution accepts ops again
                end
            end
            FLUSH: begin
                state_d = IDLE;  // single cycle flush
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // flush wins over everything else
        if (flush_i) begin
            state_d = FLUSH;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // stall and flush are also honoured in the cycle they arrive
    assign issue_en_o = (state_q == RUN) && !stall_i && !flush_i;
    assign clear_o    = (state_q == FLUSH);
    assign state_o    = state_q;

    a_en_clear_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(issue_en_o && clear_o))
        else $error("issue enable and clear high together");

endmodule

`default_nettype wire

// File: rtl/issue_pkg.sv
`default_nettype none

`include "issue_config.svh"

package issue_pkg;

    typedef logic [`TAG_W-1:0] tag_t;

    typedef logic [`AGE_W-1:0] age_t;  // 0 marks an empty entry

    // what execution needs from the op
    typedef struct packed {
        logic [5:0] opcode;
        logic [9:0] imm;
    } uop_payload_t;

    typedef struct packed {
        tag_t         dest_tag;
        tag_t         src_tag;
        logic         src_ready;  // operand already available at dispatch
        uop_payload_t payload;
    } uop_t;

    typedef struct packed {
        tag_t         dest_tag;
        uop_payload_t payload;
    } issue_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        STALL,
        FLUSH
    } ctrl_state_t;

    typedef logic [`ISSUE_DEPTH-1:0] entry_mask_t;

endpackage

`default_nettype wire

// File: rtl/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// number of issue queue entries
`define ISSUE_DEPTH 4

// physical register tag width
`define TAG_W 6

// age counter width, must hold 0 .. ISSUE_DEPTH
`define AGE_W 3

// cycles from issue to the destination tag wakeup
`define EXEC_LAT 2

`endif
